//--- rtl/sdram_map_pkg.sv
// Shared widths, SDRAM region offsets and download header constants
// Arbiter state encoding

`default_nettype none

package sdram_map_pkg;

    // Data and address widths
    typedef logic [22:0] sdram_addr_t;   // SDRAM word address
    typedef logic [15:0] word_t;         // SDRAM data word
    typedef logic [ 7:0] byte_t;         // ioctl and sound ROM data
    typedef logic [ 1:0] wmask_t;        // High bit set keeps that byte
    typedef logic [25:0] ioctl_addr_t;   // Byte address in the ROM file
    typedef logic [20:0] cpu_addr_t;     // Main CPU word address
    typedef logic [15:0] snd_addr_t;     // Sound CPU byte address

    // SDRAM layout of the single bank
    localparam sdram_addr_t ROM_OFFSET  = 23'h00_0000;
    localparam sdram_addr_t WRAM_OFFSET = 23'h30_0000;
    localparam sdram_addr_t SND_OFFSET  = 23'h38_0000;

    // ROM file header
    localparam int HDR_LEN        = 16;   // Bytes before the payload
    localparam int SND_START_UNIT = 1024; // Sound start granularity in bytes

    // Number of CPU slots sharing the bank
    localparam int NSLOT = 3;

    typedef enum logic [1:0] {
        IDLE,       // Waiting for a slot request
        WAIT_ACK,   // rd/wr raised, waiting for the bank to accept it
        WAIT_RDY    // Accepted, waiting for the data phase to end
    } arb_state_t;

endpackage

`default_nettype wire

//--- rtl/slot_req_if.sv
// Request channel between one CPU slot and the bank arbiter
// Slot side drives the request, arbiter side the done pulse and read data

`timescale 1ns/10ps
`default_nettype none

interface slot_req_if
    import sdram_map_pkg::*;
();

    logic        req;    // Held until done
    logic        we;     // Write when high
    sdram_addr_t addr;   // Already includes the region offset
    word_t       din;
    wmask_t      mask;   // Keep-byte mask
    logic        done;   // One cycle, dout valid with it
    word_t       dout;

    modport slot (
        output req, we, addr, din, mask,
        input  done, dout
    );

    modport arb (
        input  req, we, addr, din, mask,
        output done, dout
    );

endinterface

`default_nettype wire

//--- rtl/rom_hdr_regs.sv
// ROM header capture
// Bytes 0/1 give the sound ROM start in SND_START_UNIT blocks after the header

`timescale 1ns/10ps
`default_nettype none

module rom_hdr_regs
    import sdram_map_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              downloading,
    input  wire              ioctl_wr,
    input  wire ioctl_addr_t ioctl_addr,
    input  wire byte_t       ioctl_dout,
    output logic             cfg_we,
    output ioctl_addr_t      snd_start
);

    logic        hdr_wr;
    logic [15:0] snd_units;   // Sound start in blocks

    // Any write inside the header window
    assign hdr_wr = downloading && ioctl_wr && (ioctl_addr < ioctl_addr_t'(HDR_LEN));
    assign cfg_we = hdr_wr;

    // Byte 0 holds the low half of the count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_units <= '0;
        end else if (hdr_wr) begin
            if (ioctl_addr == ioctl_addr_t'(0)) begin
                snd_units[7:0] <= ioctl_dout;
            end
            if (ioctl_addr == ioctl_addr_t'(1)) begin
                snd_units[15:8] <= ioctl_dout;
            end
        end
    end

    // Relative to the first payload byte
    assign snd_start = ioctl_addr_t'(snd_units) * ioctl_addr_t'(SND_START_UNIT);

endmodule

`default_nettype wire

//--- rtl/rom_download.sv
// ROM download writer
// Pairs payload bytes into 16-bit program writes for the main and sound ROM regions
// Lone bytes at a region or file end go out with a keep mask on the other half

`timescale 1ns/10ps
`default_nettype none

module rom_download
    import sdram_map_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              downloading,
    input  wire              ioctl_wr,
    input  wire ioctl_addr_t ioctl_addr,
    input  wire byte_t       ioctl_dout,
    input  wire ioctl_addr_t snd_start,
    output sdram_addr_t      prog_addr,
    output word_t            prog_data,
    output wmask_t           prog_mask,
    output logic             prog_we,
    input  wire              prog_rdy,
    output logic             dwnld_busy
);

    ioctl_addr_t payload;     // Offset past the header
    ioctl_addr_t snd_rel;
    logic        in_snd;
    logic        payload_wr;
    logic        even_wr;
    logic        odd_wr;
    logic        flush_lone;
    logic        pair_ok;
    sdram_addr_t word_addr;

    byte_t       low_byte;    // Waiting for its high byte
    sdram_addr_t low_addr;
    logic        have_low;

    assign payload    = ioctl_addr - ioctl_addr_t'(HDR_LEN);
    assign snd_rel    = payload - snd_start;
    assign in_snd     = payload >= snd_start;
    assign payload_wr = downloading && ioctl_wr && (ioctl_addr >= ioctl_addr_t'(HDR_LEN));
    assign even_wr    = payload_wr && !ioctl_addr[0];
    assign odd_wr     = payload_wr && ioctl_addr[0];

    assign word_addr = in_snd ? SND_OFFSET + sdram_addr_t'(snd_rel >> 1)
                              : ROM_OFFSET + sdram_addr_t'(payload >> 1);

    assign pair_ok = have_low && (low_addr == word_addr);

    // Unpaired low byte, replaced by a new one or left at the end of the file
    assign flush_lone = (even_wr && have_low) || (!downloading && have_low && !prog_we);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we  <= 1'b0;
            have_low <= 1'b0;
        end else begin
            if (odd_wr || flush_lone) begin
                prog_we <= 1'b1;
            end else if (prog_rdy) begin
                prog_we <= 1'b0;      // Low the cycle after rdy
            end
            if (even_wr) begin
                have_low <= 1'b1;
            end else if (odd_wr || flush_lone) begin
                have_low <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (even_wr) begin
            low_byte <= ioctl_dout;
            low_addr <= word_addr;
        end
        if (odd_wr) begin
            prog_addr <= word_addr;
            if (pair_ok) begin
                prog_data <= {ioctl_dout, low_byte};
                prog_mask <= 2'b00;
            end else begin
                prog_data <= {ioctl_dout, 8'h00};
                prog_mask <= 2'b01;   // High byte only
            end
        end else if (flush_lone) begin
            prog_addr <= low_addr;
            prog_data <= {8'h00, low_byte};
            prog_mask <= 2'b10;       // Low byte only
        end
    end

    assign dwnld_busy = downloading || prog_we || have_low;

endmodule

`default_nettype wire

//--- rtl/slot_cache.sv
// One CPU slot in front of the bank arbiter
// Single address/word cache, read miss fill and write-through
// wmask is a byte enable here and goes out as a keep mask

`timescale 1ns/10ps
`default_nettype none

module slot_cache
    import sdram_map_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              cs,
    input  wire              wen,
    input  wire sdram_addr_t addr,
    input  wire word_t       din,
    input  wire wmask_t      wmask,   // Byte enables
    output logic             ok,
    output word_t            dout,
    slot_req_if.slot         req
);

    sdram_addr_t cache_addr;
    word_t       cache_data;
    logic        valid;

    sdram_addr_t wr_addr;     // Last completed write
    logic        wr_done;

    logic        hit;
    logic        wr_served;
    logic        start_req;

    assign hit       = valid && (cache_addr == addr);
    assign wr_served = wr_done && (wr_addr == addr);

    // Writes always go to the bank, reads only on a miss
    assign start_req = cs && !req.req && (wen ? !wr_served : !hit);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req.req <= 1'b0;
            valid   <= 1'b0;
            wr_done <= 1'b0;
            ok      <= 1'b0;
        end else begin
            if (start_req) begin
                req.req <= 1'b1;
            end else if (req.done) begin
                req.req <= 1'b0;
            end
            if (req.done && !req.we) begin
                valid <= 1'b1;
            end
            if (req.done && req.we) begin
                wr_done <= 1'b1;
            end else if (!cs || !wen) begin
                wr_done <= 1'b0;
            end
            ok <= cs && (wen ? wr_served : hit);  // Drops a cycle after cs or addr
        end
    end

    always_ff @(posedge clk) begin
        if (start_req) begin
            req.we   <= wen;
            req.addr <= addr;
            req.din  <= din;
            req.mask <= ~wmask;
        end
        if (req.done) begin
            if (!req.we) begin
                cache_addr <= req.addr;       // Fill
                cache_data <= req.dout;
            end else begin
                wr_addr <= req.addr;
                if (cache_addr == req.addr) begin
                    if (!req.mask[1]) cache_data[15:8] <= req.din[15:8];
                    if (!req.mask[0]) cache_data[7:0]  <= req.din[7:0];
                end
            end
        end
    end

    assign dout = cache_data;

endmodule

`default_nettype wire

//--- rtl/bank_arbiter.sv
// Rotating-priority arbiter for three slots on one SDRAM bank
// One bank access at a time, grants held off while hold is high

`timescale 1ns/10ps
`default_nettype none

module bank_arbiter
    import sdram_map_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              hold,
    slot_req_if.arb          req0,
    slot_req_if.arb          req1,
    slot_req_if.arb          req2,
    output sdram_addr_t      ba_addr,
    output logic             ba_rd,
    output logic             ba_wr,
    output word_t            ba_din,
    output wmask_t           ba_din_m,
    input  wire              ba_ack,
    input  wire              ba_rdy,
    input  wire word_t       data_read
);

    arb_state_t       state;
    logic [NSLOT-1:0] reqs;
    logic [NSLOT-1:0] done_q;
    logic [1:0]       last;       // Slot served last, or being served
    logic [1:0]       pick;
    logic             found;
    logic             grant;
    word_t            dout_q;

    sdram_addr_t      pick_addr;
    word_t            pick_din;
    wmask_t           pick_mask;
    logic             pick_we;

    assign reqs = {req2.req, req1.req, req0.req};

    // First requester after the last one served
    always_comb begin
        logic [1:0] idx;
        pick  = last;
        found = 1'b0;
        for (int i = 1; i <= NSLOT; i++) begin
            idx = 2'((32'(last) + i) % NSLOT);
            if (!found && reqs[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    always_comb begin
        case (pick)
            2'd1: begin
                pick_addr = req1.addr;
                pick_din  = req1.din;
                pick_mask = req1.mask;
                pick_we   = req1.we;
            end
            2'd2: begin
                pick_addr = req2.addr;
                pick_din  = req2.din;
                pick_mask = req2.mask;
                pick_we   = req2.we;
            end
            default: begin
                pick_addr = req0.addr;
                pick_din  = req0.din;
                pick_mask = req0.mask;
                pick_we   = req0.we;
            end
        endcase
    end

    // No grant during the done cycle, the served slot still shows req
    assign grant = (state == IDLE) && !hold && found && (done_q == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            ba_rd  <= 1'b0;
            ba_wr  <= 1'b0;
            done_q <= '0;
            last   <= 2'(NSLOT - 1);  // Slot 0 first
        end else begin
            done_q <= '0;
            case (state)
                IDLE: if (grant) begin
                    ba_rd <= !pick_we;
                    ba_wr <= pick_we;
                    last  <= pick;
                    state <= WAIT_ACK;
                end
                WAIT_ACK: if (ba_ack) begin
                    ba_rd <= 1'b0;
                    ba_wr <= 1'b0;
                    state <= WAIT_RDY;
                end
                WAIT_RDY: if (ba_rdy) begin
                    done_q[last] <= 1'b1;
                    state        <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            ba_addr  <= pick_addr;
            ba_din   <= pick_din;
            ba_din_m <= pick_mask;
        end
        if (state == WAIT_RDY && ba_rdy) dout_q <= data_read;
    end

    assign req0.done = done_q[0];
    assign req1.done = done_q[1];
    assign req2.done = done_q[2];
    assign req0.dout = dout_q;
    assign req1.dout = dout_q;
    assign req2.dout = dout_q;

endmodule

`default_nettype wire

//--- rtl/sdram_map.sv
// SDRAM memory map top level for a single bank
// Header registers, download writer, RAM/ROM/sound slots and bank arbiter

`timescale 1ns/10ps
`default_nettype none

module sdram_map
    import sdram_map_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire              downloading,
    input  wire              ioctl_wr,
    input  wire ioctl_addr_t ioctl_addr,
    input  wire byte_t       ioctl_dout,
    output logic             cfg_we,
    output logic             dwnld_busy,
    output sdram_addr_t      prog_addr,
    output word_t            prog_data,
    output wmask_t           prog_mask,
    output logic             prog_we,
    input  wire              prog_rdy,
    // Main CPU work RAM
    input  wire              main_ram_cs,
    input  wire              main_rnw,
    input  wire cpu_addr_t   main_ram_addr,
    input  wire word_t       main_dout,
    input  wire wmask_t      dsn,
    output logic             main_ram_ok,
    output word_t            main_ram_data,
    // Main CPU ROM
    input  wire              main_rom_cs,
    input  wire cpu_addr_t   main_rom_addr,
    output logic             main_rom_ok,
    output word_t            main_rom_data,
    // Sound CPU ROM
    input  wire              snd_cs,
    input  wire snd_addr_t   snd_addr,
    output logic             snd_ok,
    output byte_t            snd_data,
    // SDRAM bank
    output sdram_addr_t      ba_addr,
    output logic             ba_rd,
    output logic             ba_wr,
    output word_t            ba_din,
    output wmask_t           ba_din_m,
    input  wire              ba_ack,
    input  wire              ba_rdy,
    input  wire word_t       data_read
);

    ioctl_addr_t snd_start;
    sdram_addr_t ram_addr, rom_addr, snd_word_addr;
    word_t       snd_word;

    slot_req_if ram_req ();
    slot_req_if rom_req ();
    slot_req_if snd_req ();

    assign ram_addr      = WRAM_OFFSET + sdram_addr_t'(main_ram_addr[16:0]);
    assign rom_addr      = ROM_OFFSET  + sdram_addr_t'(main_rom_addr);
    assign snd_word_addr = SND_OFFSET  + sdram_addr_t'(snd_addr[15:1]);

    // Odd sound addresses read the upper byte
    assign snd_data = snd_addr[0] ? snd_word[15:8] : snd_word[7:0];

    rom_hdr_regs u_hdr (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .cfg_we      ( cfg_we      ),
        .snd_start   ( snd_start   )
    );

    rom_download u_dwnld (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .snd_start   ( snd_start   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prog_rdy    ( prog_rdy    ),
        .dwnld_busy  ( dwnld_busy  )
    );

    slot_cache u_ram_slot (
        .clk    ( clk           ),
        .arst_n ( arst_n        ),
        .cs     ( main_ram_cs   ),
        .wen    ( !main_rnw     ),
        .addr   ( ram_addr      ),
        .din    ( main_dout     ),
        .wmask  ( ~dsn          ),  // dsn is active low
        .ok     ( main_ram_ok   ),
        .dout   ( main_ram_data ),
        .req    ( ram_req       )
    );

    slot_cache u_rom_slot (
        .clk    ( clk           ),
        .arst_n ( arst_n        ),
        .cs     ( main_rom_cs   ),
        .wen    ( 1'b0          ),
        .addr   ( rom_addr      ),
        .din    ( '0            ),
        .wmask  ( '0            ),
        .ok     ( main_rom_ok   ),
        .dout   ( main_rom_data ),
        .req    ( rom_req       )
    );

    slot_cache u_snd_slot (
        .clk    ( clk           ),
        .arst_n ( arst_n        ),
        .cs     ( snd_cs        ),
        .wen    ( 1'b0          ),
        .addr   ( snd_word_addr ),
        .din    ( '0            ),
        .wmask  ( '0            ),
        .ok     ( snd_ok        ),
        .dout   ( snd_word      ),
        .req    ( snd_req       )
    );

    bank_arbiter u_arb (
        .clk       ( clk         ),
        .arst_n    ( arst_n      ),
        .hold      ( downloading ),  // Bank belongs to the download
        .req0      ( ram_req     ),
        .req1      ( rom_req     ),
        .req2      ( snd_req     ),
        .ba_addr   ( ba_addr     ),
        .ba_rd     ( ba_rd       ),
        .ba_wr     ( ba_wr       ),
        .ba_din    ( ba_din      ),
        .ba_din_m  ( ba_din_m    ),
        .ba_ack    ( ba_ack      ),
        .ba_rdy    ( ba_rdy      ),
        .data_read ( data_read   )
    );

endmodule

`default_nettype wire

//--- dv/sdram_bank_model.sv
// Behavioral SDRAM bank for the testbench
// CPU port with fixed ack and rdy delays, program write port with a one-cycle rdy

`timescale 1ns/10ps
`default_nettype none

module sdram_bank_model
    import sdram_map_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire sdram_addr_t ba_addr,
    input  wire              ba_rd,
    input  wire              ba_wr,
    input  wire word_t       ba_din,
    input  wire wmask_t      ba_din_m,
    output logic             ba_ack,
    output logic             ba_rdy,
    output word_t            data_read,
    input  wire sdram_addr_t prog_addr,
    input  wire word_t       prog_data,
    input  wire wmask_t      prog_mask,
    input  wire              prog_we,
    output logic             prog_rdy
);

    word_t       mem [sdram_addr_t];  // Sparse, only written words stored
    logic [2:0]  phase;               // 0 when idle
    logic        op_wr;
    sdram_addr_t op_addr;
    word_t       op_din;
    wmask_t      op_keep;

    // Unwritten words read back a pattern of the whole address
    function automatic word_t read_word(sdram_addr_t a);
        return mem.exists(a) ? mem[a] : (a[15:0] ^ {9'd0, a[22:16]});
    endfunction

    task automatic write_word(sdram_addr_t a, word_t d, wmask_t keep);
        word_t w;
        w = read_word(a);
        if (!keep[1]) w[15:8] = d[15:8];
        if (!keep[0]) w[7:0] = d[7:0];
        mem[a] = w;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase     <= '0;
            ba_ack    <= 1'b0;
            ba_rdy    <= 1'b0;
            prog_rdy  <= 1'b0;
            data_read <= '0;
        end else begin
            ba_ack <= 1'b0;
            ba_rdy <= 1'b0;
            if (phase == 3'd0) begin
                if (ba_rd || ba_wr) begin
                    phase   <= 3'd1;
                    op_wr   <= ba_wr;
                    op_addr <= ba_addr;
                    op_din  <= ba_din;
                    op_keep <= ba_din_m;
                end
            end else if (phase == 3'd4) begin
                ba_rdy <= 1'b1;        // Three cycles after ack
                phase  <= 3'd0;
                if (op_wr) write_word(op_addr, op_din, op_keep);
                else data_read <= read_word(op_addr);
            end else begin
                ba_ack <= (phase == 3'd1);  // Two cycles after rd/wr
                phase  <= phase + 3'd1;
            end
            // One rdy pulse per program write
            if (prog_we && !prog_rdy) begin
                write_word(prog_addr, prog_data, prog_mask);
                prog_rdy <= 1'b1;
            end else begin
                prog_rdy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_sdram_map.sv
// Testbench for the single-bank SDRAM memory map
// ROM download with header, then a table of ROM, sound and work RAM accesses
// Reference memory, compare tasks, bank read counter and cycle timeout

`timescale 1ns/10ps
`default_nettype none

module tb_sdram_map
    import sdram_map_pkg::*;
();

    localparam int PAYLOAD   = 2048;
    localparam int FILE_LEN  = HDR_LEN + PAYLOAD;
    localparam int SND_UNITS = 1;
    localparam int SND_BYTES = SND_UNITS * SND_START_UNIT;  // Payload offset of sound ROM

    typedef enum logic [2:0] {ROM_RD, ROM_HIT, SND_RD, RAM_WR, RAM_RD, ALL_RD} op_t;

    typedef struct packed {
        op_t         op;
        logic [16:0] addr;
        word_t       data;
        wmask_t      dsn;
        word_t       exp_rom;
        word_t       exp_ram;
        byte_t       exp_snd;
    } entry_t;

    logic        clk;
    logic        arst_n;
    logic        downloading, ioctl_wr;
    ioctl_addr_t ioctl_addr;
    byte_t       ioctl_dout;
    logic        cfg_we, dwnld_busy;
    sdram_addr_t prog_addr;
    word_t       prog_data;
    wmask_t      prog_mask;
    logic        prog_we, prog_rdy;
    logic        main_ram_cs, main_rnw, main_ram_ok;
    cpu_addr_t   main_ram_addr, main_rom_addr;
    word_t       main_dout, main_ram_data, main_rom_data;
    wmask_t      dsn;
    logic        main_rom_cs, main_rom_ok;
    logic        snd_cs, snd_ok;
    snd_addr_t   snd_addr;
    byte_t       snd_data;
    sdram_addr_t ba_addr;
    logic        ba_rd, ba_wr, ba_ack, ba_rdy;
    word_t       ba_din, data_read;
    wmask_t      ba_din_m;

    byte_t       file_bytes [FILE_LEN];
    word_t       ref_mem [sdram_addr_t];
    entry_t      tbl [$];

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int prog_count = 0;   // Program writes seen
    int rd_count = 0;     // ba_rd pulses seen
    int cycles = 0;
    int cycle_limit = 1_000_000;
    logic ba_rd_q = 1'b0;

    sdram_map u_sdram_map (.*);
    sdram_bank_model u_bank (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(string name, word_t exp, word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_byte(string name, byte_t exp, byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(string name, sdram_addr_t exp, sdram_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_mask(string name, wmask_t exp, wmask_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic report_test(string name, int err0);
        tests++;
        if (errors == err0) $display("test %s ok", name);
        else $display("test %s had %0d errors", name, errors - err0);
    endtask

    // Where a payload byte lands in the bank
    function automatic sdram_addr_t payload_addr(int p);
        if (p < SND_BYTES) begin
            return ROM_OFFSET + sdram_addr_t'(p / 2);
        end
        return SND_OFFSET + sdram_addr_t'((p - SND_BYTES) / 2);
    endfunction

    function automatic word_t ref_word(sdram_addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : '0;
    endfunction

    task automatic add_entry(op_t op, logic [16:0] addr, word_t data, wmask_t dsn_v);
        entry_t      e;
        sdram_addr_t ra;
        word_t       w;
        ra = WRAM_OFFSET + sdram_addr_t'(addr);
        if (op == RAM_WR) begin
            w = ref_word(ra);
            if (!dsn_v[1]) w[15:8] = data[15:8];   // Active-low byte selects
            if (!dsn_v[0]) w[7:0] = data[7:0];
            ref_mem[ra] = w;
        end
        e.op      = op;
        e.addr    = addr;
        e.data    = data;
        e.dsn     = dsn_v;
        e.exp_rom = ref_word(ROM_OFFSET + sdram_addr_t'(addr));
        e.exp_ram = ref_word(ra);
        w         = ref_word(SND_OFFSET + sdram_addr_t'(addr[15:1]));
        e.exp_snd = addr[0] ? w[15:8] : w[7:0];
        tbl.push_back(e);
    endtask

    function automatic logic slot_ok(op_t op);
        case (op)
            ROM_RD, ROM_HIT: return main_rom_ok;
            SND_RD:          return snd_ok;
            RAM_WR, RAM_RD:  return main_ram_ok;
            default:         return main_rom_ok && main_ram_ok && snd_ok;
        endcase
    endfunction

    // Header is a byte-wide stream, two cycles per byte
    task automatic download_rom();
        int err0;
        err0 = errors;
        @(negedge clk);
        downloading = 1'b1;
        for (int i = 0; i < FILE_LEN; i++) begin
            @(negedge clk);
            check_flag($sformatf("cfg_we_idle_%0d", i), 1'b0, cfg_we);
            ioctl_addr = ioctl_addr_t'(i);
            ioctl_dout = file_bytes[i];
            ioctl_wr   = 1'b1;
            @(negedge clk);
            // Only the first HDR_LEN bytes are configuration
            check_flag($sformatf("cfg_we_byte_%0d", i), i < HDR_LEN, cfg_we);
            check_flag($sformatf("dwnld_busy_byte_%0d", i), 1'b1, dwnld_busy);
            ioctl_wr = 1'b0;
        end
        @(negedge clk);
        downloading = 1'b0;
        do @(negedge clk); while (dwnld_busy);
        check_flag("cfg_we_after_download", 1'b0, cfg_we);
        checks++;
        if (prog_count != PAYLOAD / 2) begin
            errors++;
            $display("Download made %0d program writes instead of %0d", prog_count, PAYLOAD / 2);
        end
        report_test("download", err0);
    endtask

    task automatic run_entry(entry_t e, int idx);
        string name;
        op_t   op;
        int    err0;
        int    rd0;
        op   = e.op;
        name = $sformatf("%0d_%s_%h", idx, op.name(), e.addr);
        err0 = errors;
        rd0  = rd_count;
        @(negedge clk);
        if (op == ROM_RD || op == ROM_HIT || op == ALL_RD) begin
            main_rom_addr = cpu_addr_t'(e.addr);
            main_rom_cs   = 1'b1;
        end
        if (op == SND_RD || op == ALL_RD) begin
            snd_addr = e.addr[15:0];
            snd_cs   = 1'b1;
        end
        if (op == RAM_WR || op == RAM_RD || op == ALL_RD) begin
            main_ram_addr = cpu_addr_t'(e.addr);
            main_rnw      = (op != RAM_WR);
            main_dout     = e.data;
            dsn           = e.dsn;
            main_ram_cs   = 1'b1;
        end
        do @(negedge clk); while (!slot_ok(op));
        case (op)
            ROM_RD:  check_word(name, e.exp_rom, main_rom_data);
            ROM_HIT: begin
                check_word(name, e.exp_rom, main_rom_data);
                checks++;
                if (rd_count != rd0) begin
                    errors++;
                    $display("%s went to the bank although the word was cached", name);
                end
            end
            SND_RD:  check_byte(name, e.exp_snd, snd_data);
            RAM_RD:  check_word(name, e.exp_ram, main_ram_data);
            ALL_RD: begin
                check_word({name, "_rom"}, e.exp_rom, main_rom_data);
                check_word({name, "_ram"}, e.exp_ram, main_ram_data);
                check_byte({name, "_snd"}, e.exp_snd, snd_data);
            end
            default: ;  // Write completes with ok
        endcase
        main_rom_cs = 1'b0;
        main_ram_cs = 1'b0;
        snd_cs      = 1'b0;
        @(negedge clk);
        report_test(name, err0);
    endtask

    // Program writes complete in the cycle where we and rdy are both high
    always @(negedge clk) begin : bank_monitor
        int    p;
        string name;
        if (prog_we && prog_rdy) begin
            p    = 2 * prog_count;
            name = $sformatf("prog_write_%0d", prog_count);
            if (p < PAYLOAD) begin
                check_addr(name, payload_addr(p), prog_addr);
                check_word(name, {file_bytes[HDR_LEN + p + 1], file_bytes[HDR_LEN + p]},
                           prog_data);
                check_mask(name, 2'b00, prog_mask);
            end else begin
                errors++;
                $display("Program write %0d goes past the end of the file", prog_count);
            end
            prog_count++;
        end
        if (ba_rd && !ba_rd_q) rd_count++;
        ba_rd_q = ba_rd;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles waiting for a DUT response", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin : main
        void'($urandom(32'hc257));
        arst_n        = 1'b0;
        downloading   = 1'b0;
        ioctl_wr      = 1'b0;
        ioctl_addr    = '0;
        ioctl_dout    = '0;
        main_ram_cs   = 1'b0;
        main_rnw      = 1'b1;
        main_ram_addr = '0;
        main_dout     = '0;
        dsn           = 2'b11;
        main_rom_cs   = 1'b0;
        main_rom_addr = '0;
        snd_cs        = 1'b0;
        snd_addr      = '0;

        for (int i = 0; i < FILE_LEN; i++) file_bytes[i] = byte_t'($urandom);
        file_bytes[0] = byte_t'(SND_UNITS);   // Sound start count, low byte first
        file_bytes[1] = 8'h00;
        for (int p = 0; p < PAYLOAD; p += 2) begin
            ref_mem[payload_addr(p)] = {file_bytes[HDR_LEN + p + 1], file_bytes[HDR_LEN + p]};
        end

        add_entry(ROM_RD,  17'h00000, '0, 2'b11);
        add_entry(ROM_RD,  17'h00001, '0, 2'b11);
        add_entry(ROM_RD,  17'h001ff, '0, 2'b11);
        add_entry(ROM_RD,  17'h00100, '0, 2'b11);
        add_entry(ROM_HIT, 17'h00100, '0, 2'b11);
        add_entry(SND_RD,  17'h00000, '0, 2'b11);
        add_entry(SND_RD,  17'h00001, '0, 2'b11);
        add_entry(SND_RD,  17'h003fe, '0, 2'b11);
        add_entry(SND_RD,  17'h003ff, '0, 2'b11);
        add_entry(SND_RD,  17'h00155, '0, 2'b11);
        add_entry(RAM_WR,  17'h00010, 16'h1234, 2'b00);
        add_entry(RAM_RD,  17'h00010, '0, 2'b11);
        add_entry(RAM_WR,  17'h00010, 16'hab77, 2'b01);  // Upper byte only
        add_entry(RAM_RD,  17'h00010, '0, 2'b11);
        add_entry(RAM_WR,  17'h00010, 16'h88cd, 2'b10);  // Lower byte only
        add_entry(RAM_RD,  17'h00010, '0, 2'b11);
        add_entry(RAM_WR,  17'h00010, 16'hffff, 2'b11);
        add_entry(RAM_RD,  17'h00010, '0, 2'b11);
        add_entry(RAM_WR,  17'h1ffff, 16'h5a5a, 2'b00);
        add_entry(RAM_RD,  17'h1ffff, '0, 2'b11);
        add_entry(RAM_WR,  17'h00020, 16'hc0de, 2'b00);
        add_entry(ALL_RD,  17'h00020, '0, 2'b11);
        add_entry(ROM_HIT, 17'h00020, '0, 2'b11);
        cycle_limit = 2 * FILE_LEN + 20 + 40 * tbl.size();

        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        download_rom();
        foreach (tbl[i]) run_entry(tbl[i], i);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sdram_map.f
rtl/sdram_map_pkg.sv
rtl/slot_req_if.sv
rtl/rom_hdr_regs.sv
rtl/rom_download.sv
rtl/slot_cache.sv
rtl/bank_arbiter.sv
rtl/sdram_map.sv
dv/sdram_bank_model.sv
dv/tb_sdram_map.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_sdram_map -f sdram_map.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Testbench passed" sim.log && exit 0 || exit 1
